/* Makefile */
# Verilator build of the plic testbench

VERILATOR ?= verilator
TOP       ?= plic_tb
FILELIST  ?= plic.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* design/plic_bus_pkg.sv */
`default_nettype none

`include "plic_params.svh"

// register bus between the hart ports and the register block
package plic_bus_pkg;

    // index of the hart port that issued a request
    typedef logic [$clog2(`PLIC_NPORT)-1:0] port_tag_t;

    typedef struct packed {
        logic                    wr;     // 1 = write, 0 = read
        logic [`PLIC_ADDR_W-1:0] addr;   // word address
        logic [`PLIC_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [`PLIC_DATA_W-1:0] rdata;
    } reg_rsp_t;

endpackage

`default_nettype wire

/* design/plic_gateway.sv */
`timescale 1ns/100ps
`default_nettype none

`include "plic_params.svh"

module plic_gateway (
    input  wire                                         clk,
    input  wire                                         nrst,
    input  wire [`PLIC_NSRC-1:0]                        i_irq,
    input  wire plic_irq_pkg::prio_t [`PLIC_NSRC-1:0]   i_prio,
    input  wire plic_irq_pkg::claim_t [`PLIC_NCTX-1:0]  i_claim,
    input  wire plic_irq_pkg::claim_t                   i_complete,
    output logic [`PLIC_NSRC-1:0]                       o_pending
);
    import plic_irq_pkg::*;

    logic [`PLIC_NSRC-1:0] pend_q, pend_d;
    logic [`PLIC_NSRC-1:0] insvc_q, insvc_d;  // claimed, waiting for complete
    logic [`PLIC_NSRC-1:0] prio_nz;
    logic [`PLIC_NSRC-1:0] claimed;
    logic [`PLIC_NSRC-1:0] completed;

    always_comb begin
        prio_nz   = '0;  // slot 0 keeps all of these clear
        claimed   = '0;
        completed = '0;
        for (int s = 1; s < `PLIC_NSRC; s++) begin
            prio_nz[s]   = i_prio[s] != '0;
            completed[s] = i_complete.stb && (i_complete.id == src_id_t'(s));
            for (int c = 0; c < `PLIC_NCTX; c++) begin
                if (i_claim[c].stb && (i_claim[c].id == src_id_t'(s))) begin
                    claimed[s] = 1'b1;
                end
            end
        end
        // level arms only an idle source with a priority, claim wins
        pend_d  = (pend_q | (i_irq & prio_nz & ~insvc_q)) & ~claimed;
        insvc_d = (insvc_q | claimed) & ~completed;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pend_q  <= '0;
            insvc_q <= '0;
        end else begin
            pend_q  <= pend_d;
            insvc_q <= insvc_d;
        end
    end

    assign o_pending = pend_q;

    a_pend_excl: assert property (@(posedge clk) disable iff (!nrst)
        (pend_q & insvc_q) == '0);

endmodule

`default_nettype wire

/* design/plic_irq_pkg.sv */
`default_nettype none

`include "plic_params.svh"

// interrupt side: priorities, source ids and per-context setup
package plic_irq_pkg;

    typedef logic [`PLIC_PRIO_W-1:0] prio_t;  // priority or threshold

    // source number, 0 means no source
    typedef logic [$clog2(`PLIC_NSRC)-1:0] src_id_t;

    // claim or complete of one source
    typedef struct packed {
        logic    stb;
        src_id_t id;
    } claim_t;

    typedef struct packed {
        logic [`PLIC_NSRC-1:0] en;      // bit 0 stays clear
        prio_t                 thresh;  // only priorities above this qualify
    } ctx_cfg_t;

endpackage

`default_nettype wire

/* design/plic_params.svh */
`ifndef PLIC_PARAMS_SVH
`define PLIC_PARAMS_SVH

// source slots, slot 0 is reserved and never fires
`define PLIC_NSRC   32

`define PLIC_NCTX   2   // interrupt contexts

// width of a source priority and of a context threshold
`define PLIC_PRIO_W 3

`define PLIC_DATA_W 32  // register data
`define PLIC_ADDR_W 8   // register word address

// hart-side register ports
`define PLIC_NPORT  2

`endif

/* design/plic_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "plic_params.svh"

module plic_regs (
    input  wire                                           clk,
    input  wire                                           nrst,
    input  wire                                           i_bus_stb,
    input  wire plic_bus_pkg::reg_req_t                   i_bus_req,
    input  wire plic_bus_pkg::port_tag_t                  i_bus_tag,
    output logic                                          o_rsp_stb,
    output plic_bus_pkg::reg_rsp_t                        o_rsp,
    output plic_bus_pkg::port_tag_t                       o_rsp_tag,
    output plic_irq_pkg::prio_t [`PLIC_NSRC-1:0]          o_prio,
    output plic_irq_pkg::ctx_cfg_t [`PLIC_NCTX-1:0]       o_cfg,
    input  wire [`PLIC_NSRC-1:0]                          i_pending,
    input  wire plic_irq_pkg::src_id_t [`PLIC_NCTX-1:0]   i_best_id,
    output plic_irq_pkg::claim_t [`PLIC_NCTX-1:0]         o_claim,
    output plic_irq_pkg::claim_t                          o_complete
);
    import plic_bus_pkg::*;
    import plic_irq_pkg::*;

    localparam logic [`PLIC_ADDR_W-1:0] ADDR_PEND = 'h20;
    localparam logic [`PLIC_ADDR_W-1:0] ADDR_EN   = 'h21;  // plus context
    localparam logic [`PLIC_ADDR_W-1:0] ADDR_THR  = 'h30;  // plus 2*context with claim one above

    prio_t [`PLIC_NSRC-1:0]    prio_q, prio_d;
    ctx_cfg_t [`PLIC_NCTX-1:0] cfg_q, cfg_d;
    claim_t [`PLIC_NCTX-1:0]   claim_q, claim_d;
    claim_t                    complete_q, complete_d;
    logic [`PLIC_DATA_W-1:0]   rdata;
    logic [`PLIC_ADDR_W-1:0]   addr;
    logic                      wr;
    logic                      rsp_stb_q;
    reg_rsp_t                  rsp_q;
    port_tag_t                 tag_q;

    assign addr = i_bus_req.addr;
    assign wr   = i_bus_stb && i_bus_req.wr;

    always_comb begin
        logic [`PLIC_ADDR_W-1:0] a_en;
        logic [`PLIC_ADDR_W-1:0] a_thr;
        prio_d     = prio_q;
        cfg_d      = cfg_q;
        claim_d    = '0;
        complete_d = '0;
        rdata      = '0;

        if (addr < `PLIC_ADDR_W'(`PLIC_NSRC)) begin
            rdata[`PLIC_PRIO_W-1:0] = prio_q[src_id_t'(addr)];
            if (wr && addr != '0) begin  // source 0 has no priority
                prio_d[src_id_t'(addr)] = prio_t'(i_bus_req.wdata);
            end
        end
        if (addr == ADDR_PEND) begin
            rdata[`PLIC_NSRC-1:0] = i_pending;  // read-only
        end

        for (int c = 0; c < `PLIC_NCTX; c++) begin
            a_en  = ADDR_EN + `PLIC_ADDR_W'(c);
            a_thr = ADDR_THR + `PLIC_ADDR_W'(2 * c);
            if (addr == a_en) begin
                rdata[`PLIC_NSRC-1:0] = cfg_q[c].en;
                if (wr) begin
                    cfg_d[c].en    = i_bus_req.wdata[`PLIC_NSRC-1:0];
                    cfg_d[c].en[0] = 1'b0;
                end
            end
            if (addr == a_thr) begin
                rdata[`PLIC_PRIO_W-1:0] = cfg_q[c].thresh;
                if (wr) begin
                    cfg_d[c].thresh = prio_t'(i_bus_req.wdata);
                end
            end
            if (addr == a_thr + 1'b1) begin
                if (wr) begin
                    complete_d.id  = src_id_t'(i_bus_req.wdata);
                    complete_d.stb = complete_d.id != '0;
                end else begin
                    // the id returned here is the one claimed
                    rdata[$bits(src_id_t)-1:0] = i_best_id[c];
                    claim_d[c].id              = i_best_id[c];
                    claim_d[c].stb             = i_bus_stb && i_best_id[c] != '0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            prio_q     <= '0;
            cfg_q      <= '0;
            claim_q    <= '0;
            complete_q <= '0;
            rsp_stb_q  <= 1'b0;
        end else begin
            prio_q     <= prio_d;
            cfg_q      <= cfg_d;
            claim_q    <= claim_d;
            complete_q <= complete_d;
            rsp_stb_q  <= i_bus_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (i_bus_stb) begin
            rsp_q.rdata <= rdata;
            tag_q       <= i_bus_tag;
        end
    end

    assign o_rsp_stb  = rsp_stb_q;
    assign o_rsp      = rsp_q;
    assign o_rsp_tag  = tag_q;
    assign o_prio     = prio_q;
    assign o_cfg      = cfg_q;
    assign o_claim    = claim_q;
    assign o_complete = complete_q;

    // a claim always names a real source
    for (genvar c = 0; c < `PLIC_NCTX; c++) begin : g_claim_chk
        a_claim_id: assert property (@(posedge clk) disable iff (!nrst)
            o_claim[c].stb |-> o_claim[c].id != '0);
    end

endmodule

`default_nettype wire

/* design/plic_target.sv */
`timescale 1ns/100ps
`default_nettype none

`include "plic_params.svh"

module plic_target (
    input  wire                                           clk,
    input  wire                                           nrst,
    input  wire [`PLIC_NSRC-1:0]                          i_pending,
    input  wire plic_irq_pkg::prio_t [`PLIC_NSRC-1:0]     i_prio,
    input  wire plic_irq_pkg::ctx_cfg_t [`PLIC_NCTX-1:0]  i_cfg,
    output plic_irq_pkg::src_id_t [`PLIC_NCTX-1:0]        o_best_id,
    output logic [`PLIC_NCTX-1:0]                         o_ip
);
    import plic_irq_pkg::*;

    src_id_t [`PLIC_NCTX-1:0] best_id_d, best_id_q;
    logic [`PLIC_NCTX-1:0]    ip_d, ip_q;

    always_comb begin
        prio_t best_prio;
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            best_prio    = '0;
            best_id_d[c] = '0;
            for (int s = 1; s < `PLIC_NSRC; s++) begin
                // strict compare keeps the lowest id on a tie
                if (i_pending[s] && i_cfg[c].en[s]
                    && (i_prio[s] > i_cfg[c].thresh)
                    && (i_prio[s] > best_prio)) begin
                    best_prio    = i_prio[s];
                    best_id_d[c] = src_id_t'(s);
                end
            end
            ip_d[c] = best_prio != '0;  // line raised from the winning priority
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            best_id_q <= '0;
            ip_q      <= '0;
        end else begin
            best_id_q <= best_id_d;
            ip_q      <= ip_d;
        end
    end

    assign o_best_id = best_id_q;
    assign o_ip      = ip_q;

    for (genvar c = 0; c < `PLIC_NCTX; c++) begin : g_ip_chk
        a_ip_has_id: assert property (@(posedge clk) disable iff (!nrst)
            o_ip[c] |-> o_best_id[c] != '0);
    end

endmodule

`default_nettype wire

/* design/plic_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "plic_params.svh"

module plic_top (
    input  wire                                           clk,
    input  wire                                           nrst,
    input  wire [`PLIC_NSRC-1:0]                          i_irq,   // bit 0 unused
    input  wire [`PLIC_NPORT-1:0]                         i_req_stb,
    input  wire plic_bus_pkg::reg_req_t [`PLIC_NPORT-1:0] i_req,
    output logic [`PLIC_NPORT-1:0]                        o_rsp_stb,
    output plic_bus_pkg::reg_rsp_t [`PLIC_NPORT-1:0]      o_rsp,
    output logic [`PLIC_NCTX-1:0]                         o_ip
);
    import plic_bus_pkg::*;
    import plic_irq_pkg::*;

    logic                      bus_stb;
    reg_req_t                  bus_req;
    port_tag_t                 bus_tag;
    logic                      rsp_stb;
    reg_rsp_t                  rsp;
    port_tag_t                 rsp_tag;
    prio_t [`PLIC_NSRC-1:0]    prio_vec;
    ctx_cfg_t [`PLIC_NCTX-1:0] cfg;
    claim_t [`PLIC_NCTX-1:0]   claim;
    claim_t                    complete;
    logic [`PLIC_NSRC-1:0]     pending;
    src_id_t [`PLIC_NCTX-1:0]  best_id;

    reg_arbiter i_arbiter (
        .clk       (clk),
        .nrst      (nrst),
        .i_req_stb (i_req_stb),
        .i_req     (i_req),
        .o_bus_stb (bus_stb),
        .o_bus_req (bus_req),
        .o_bus_tag (bus_tag),
        .i_rsp_stb (rsp_stb),
        .i_rsp     (rsp),
        .i_rsp_tag (rsp_tag),
        .o_rsp_stb (o_rsp_stb),
        .o_rsp     (o_rsp)
    );

    plic_regs i_regs (
        .clk        (clk),
        .nrst       (nrst),
        .i_bus_stb  (bus_stb),
        .i_bus_req  (bus_req),
        .i_bus_tag  (bus_tag),
        .o_rsp_stb  (rsp_stb),
        .o_rsp      (rsp),
        .o_rsp_tag  (rsp_tag),
        .o_prio     (prio_vec),
        .o_cfg      (cfg),
        .i_pending  (pending),
        .i_best_id  (best_id),
        .o_claim    (claim),
        .o_complete (complete)
    );

    plic_gateway i_gateway (
        .clk        (clk),
        .nrst       (nrst),
        .i_irq      (i_irq),
        .i_prio     (prio_vec),
        .i_claim    (claim),
        .i_complete (complete),
        .o_pending  (pending)
    );

    plic_target i_target (
        .clk       (clk),
        .nrst      (nrst),
        .i_pending (pending),
        .i_prio    (prio_vec),
        .i_cfg     (cfg),
        .o_best_id (best_id),
        .o_ip      (o_ip)
    );

endmodule

`default_nettype wire

/* design/reg_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "plic_params.svh"

module reg_arbiter (
    input  wire                                           clk,
    input  wire                                           nrst,
    input  wire [`PLIC_NPORT-1:0]                         i_req_stb,
    input  wire plic_bus_pkg::reg_req_t [`PLIC_NPORT-1:0] i_req,
    output logic                                          o_bus_stb,
    output plic_bus_pkg::reg_req_t                        o_bus_req,
    output plic_bus_pkg::port_tag_t                       o_bus_tag,
    input  wire                                           i_rsp_stb,
    input  wire plic_bus_pkg::reg_rsp_t                   i_rsp,
    input  wire plic_bus_pkg::port_tag_t                  i_rsp_tag,
    output logic [`PLIC_NPORT-1:0]                        o_rsp_stb,
    output plic_bus_pkg::reg_rsp_t [`PLIC_NPORT-1:0]      o_rsp
);
    import plic_bus_pkg::*;

    reg_req_t [`PLIC_NPORT-1:0] req_q;   // held request per port
    logic [`PLIC_NPORT-1:0]     wait_q;  // held and not yet issued
    logic [`PLIC_NPORT-1:0]     busy_q;  // strobe seen, response not back yet
    port_tag_t                  last_q;  // last granted port
    port_tag_t                  gnt;
    logic                       gnt_vld;
    logic [`PLIC_NPORT-1:0]     gnt_oh;

    // search starts at the port after the last grant
    always_comb begin
        int idx;
        gnt_vld = 1'b0;
        gnt     = last_q;
        for (int k = 1; k <= `PLIC_NPORT; k++) begin
            idx = (int'(last_q) + k) % `PLIC_NPORT;
            if (!gnt_vld && wait_q[idx]) begin
                gnt_vld = 1'b1;
                gnt     = port_tag_t'(idx);
            end
        end
        gnt_oh      = '0;
        gnt_oh[gnt] = gnt_vld;
    end

    assign o_bus_stb = gnt_vld;
    assign o_bus_req = req_q[gnt];
    assign o_bus_tag = gnt;

    // response goes back to the port named by the echoed tag
    always_comb begin
        for (int p = 0; p < `PLIC_NPORT; p++) begin
            o_rsp_stb[p] = i_rsp_stb && (i_rsp_tag == port_tag_t'(p));
            o_rsp[p]     = i_rsp;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wait_q <= '0;
            busy_q <= '0;
            last_q <= '0;
        end else begin
            wait_q <= (wait_q & ~gnt_oh) | i_req_stb;
            busy_q <= (busy_q & ~o_rsp_stb) | i_req_stb;
            if (gnt_vld) begin
                last_q <= gnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `PLIC_NPORT; p++) begin
            if (i_req_stb[p]) begin
                req_q[p] <= i_req[p];
            end
        end
    end

    // a new strobe is legal only once the previous response is out
    a_one_outstanding: assert property (@(posedge clk) disable iff (!nrst)
        (i_req_stb & busy_q & ~o_rsp_stb) == '0);

endmodule

`default_nettype wire

/* plic.f */
+incdir+design
design/plic_bus_pkg.sv
design/plic_irq_pkg.sv
design/reg_arbiter.sv
design/plic_regs.sv
design/plic_gateway.sv
design/plic_target.sv
design/plic_top.sv
sim/plic_tb.sv

/* sim/plic_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "plic_params.svh"

module plic_tb;
    import plic_bus_pkg::*;
    import plic_irq_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 4;
    localparam int RSP_LIMIT  = 8;  // cycles to wait for a response

    // source level sets used by the table
    localparam logic [`PLIC_NSRC-1:0] L_NONE = 32'h0000_0000;
    localparam logic [`PLIC_NSRC-1:0] L_TWO  = 32'h0000_0208;  // 3 and 9
    localparam logic [`PLIC_NSRC-1:0] L_MANY = 32'h0000_16f8;  // 3..7, 9, 10, 12

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_BOTH} op_t;

    typedef struct packed {
        logic                    port;
        op_t                     op;
        logic [`PLIC_ADDR_W-1:0] addr;
        logic [`PLIC_DATA_W-1:0] wdata;
        logic [`PLIC_NSRC-1:0]   lvl;    // source levels during the row
        logic                    mrd;    // read data comes from the model
        logic                    mip;    // o_ip comes from the model
        logic [`PLIC_DATA_W-1:0] rdata;
        logic [`PLIC_NCTX-1:0]   ip;
    } row_t;

    logic                       clk;
    logic                       nrst;
    logic [`PLIC_NSRC-1:0]      irq;
    logic [`PLIC_NPORT-1:0]     req_stb;
    reg_req_t [`PLIC_NPORT-1:0] req;
    logic [`PLIC_NPORT-1:0]     rsp_stb;
    reg_rsp_t [`PLIC_NPORT-1:0] rsp;
    logic [`PLIC_NCTX-1:0]      ip;

    row_t rows[$];
    bit   table_ready;

    // reference model state
    prio_t                 m_prio [`PLIC_NSRC];
    logic [`PLIC_NSRC-1:0] m_en [`PLIC_NCTX];
    prio_t                 m_thr [`PLIC_NCTX];
    logic [`PLIC_NSRC-1:0] m_pend;
    logic [`PLIC_NSRC-1:0] m_insvc;
    int                    m_last;  // last port granted the bus

    plic_top i_dut (
        .clk       (clk),
        .nrst      (nrst),
        .i_irq     (irq),
        .i_req_stb (req_stb),
        .i_req     (req),
        .o_rsp_stb (rsp_stb),
        .o_rsp     (rsp),
        .o_ip      (ip)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [`PLIC_DATA_W-1:0] exp,
                               input logic [`PLIC_DATA_W-1:0] got);
        assert (got === exp) else begin
            stop_run($sformatf("ERROR at %0d ns: %s expected %0h, got %0h",
                               $time, name, exp, got));
        end
    endtask

    task automatic model_reset();
        for (int s = 0; s < `PLIC_NSRC; s++) begin
            m_prio[s] = '0;
        end
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            m_en[c]  = '0;
            m_thr[c] = '0;
        end
        m_pend  = '0;
        m_insvc = '0;
        m_last  = 0;
    endtask

    function automatic bit model_qualifies(input int c, input int s);
        return m_pend[s] && m_en[c][s] && (m_prio[s] > m_thr[c]);
    endfunction

    function automatic int model_best(input int c);
        prio_t top;
        int    id;
        top = '0;
        id  = 0;
        for (int s = 1; s < `PLIC_NSRC; s++) begin
            if (model_qualifies(c, s) && m_prio[s] > top) begin
                top = m_prio[s];
            end
        end
        // downward scan leaves the lowest id of the top priority
        for (int s = `PLIC_NSRC - 1; s >= 1; s--) begin
            if (model_qualifies(c, s) && m_prio[s] == top) begin
                id = s;
            end
        end
        return id;
    endfunction

    function automatic logic [`PLIC_NCTX-1:0] model_ip();
        logic [`PLIC_NCTX-1:0] v;
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            v[c] = model_best(c) != 0;
        end
        return v;
    endfunction

    // a held level arms any idle source with a nonzero priority
    task automatic model_arm(input logic [`PLIC_NSRC-1:0] lvl);
        for (int s = 1; s < `PLIC_NSRC; s++) begin
            if (lvl[s] && m_prio[s] != '0 && !m_insvc[s]) begin
                m_pend[s] = 1'b1;
            end
        end
    endtask

    function automatic logic [`PLIC_DATA_W-1:0] model_access(input logic wr,
            input logic [`PLIC_ADDR_W-1:0] addr, input logic [`PLIC_DATA_W-1:0] wdata);
        logic [`PLIC_DATA_W-1:0] data;
        int                      id;
        data = '0;
        if (addr < `PLIC_NSRC) begin
            data = m_prio[addr];
            if (wr && addr != 0) begin
                m_prio[addr] = wdata[`PLIC_PRIO_W-1:0];
            end
        end else if (addr == 8'h20) begin
            data = m_pend;
        end
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            if (addr == 8'h21 + c) begin
                data = m_en[c];
                if (wr) begin
                    m_en[c] = wdata & ~32'h1;
                end
            end else if (addr == 8'h30 + 2 * c) begin
                data = m_thr[c];
                if (wr) begin
                    m_thr[c] = wdata[`PLIC_PRIO_W-1:0];
                end
            end else if (addr == 8'h31 + 2 * c) begin
                if (wr) begin
                    id = int'(wdata[$clog2(`PLIC_NSRC)-1:0]);  // complete
                    if (id != 0) begin
                        m_insvc[id] = 1'b0;
                    end
                end else begin
                    id   = model_best(c);  // claim
                    data = id;
                    if (id != 0) begin
                        m_pend[id]  = 1'b0;
                        m_insvc[id] = 1'b1;
                    end
                end
            end
        end
        return data;
    endfunction

    task automatic add_row(input logic port, input op_t op, input logic [7:0] addr,
                           input logic [31:0] wdata, input logic [31:0] lvl, input logic mrd,
                           input logic mip, input logic [31:0] rdata, input logic [1:0] exp_ip);
        rows.push_back(row_t'{port, op, addr, wdata, lvl, mrd, mip, rdata, exp_ip});
    endtask

    task automatic build_table();
        // register access
        add_row(0, OP_WR, 8'h05, 32'h3, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(1, OP_RD, 8'h05, 32'h0, L_NONE, 0, 0, 32'h3, 2'b00);
        add_row(0, OP_WR, 8'h00, 32'h7, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(0, OP_RD, 8'h00, 32'h0, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(1, OP_WR, 8'h21, 32'hffff_ffff, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(0, OP_RD, 8'h21, 32'h0, L_NONE, 0, 0, 32'hffff_fffe, 2'b00);
        add_row(0, OP_WR, 8'h22, 32'hf0, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(1, OP_RD, 8'h22, 32'h0, L_NONE, 0, 0, 32'hf0, 2'b00);
        add_row(0, OP_WR, 8'h30, 32'h2, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(1, OP_RD, 8'h30, 32'h0, L_NONE, 0, 0, 32'h2, 2'b00);
        add_row(0, OP_WR, 8'h20, 32'hffff_ffff, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(0, OP_RD, 8'h20, 32'h0, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(1, OP_WR, 8'h40, 32'h1234, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(1, OP_RD, 8'h40, 32'h0, L_NONE, 0, 0, 32'h0, 2'b00);
        add_row(0, OP_RD, 8'h25, 32'h0, L_NONE, 0, 0, 32'h0, 2'b00);
        // gateway with source 9 left at priority 0
        add_row(0, OP_WR, 8'h03, 32'h5, L_TWO, 0, 0, 32'h0, 2'b01);
        add_row(0, OP_RD, 8'h20, 32'h0, L_TWO, 0, 0, 32'h8, 2'b01);
        // random priorities stay below source 3
        add_row(1, OP_WR, 8'h04, $urandom_range(4, 1), L_TWO, 0, 0, 32'h0, 2'b01);
        add_row(0, OP_WR, 8'h06, $urandom_range(4, 1), L_TWO, 0, 0, 32'h0, 2'b01);
        add_row(1, OP_WR, 8'h07, $urandom_range(4, 1), L_TWO, 0, 0, 32'h0, 2'b01);
        add_row(0, OP_RD, 8'h04, 32'h0, L_MANY, 1, 0, 32'h0, 2'b11);
        // tie between 10 and 12 on context 1
        add_row(1, OP_WR, 8'h0a, 32'h6, L_MANY, 0, 0, 32'h0, 2'b11);
        add_row(0, OP_WR, 8'h0c, 32'h6, L_MANY, 0, 0, 32'h0, 2'b11);
        add_row(1, OP_WR, 8'h22, 32'h1400, L_MANY, 0, 0, 32'h0, 2'b11);
        add_row(1, OP_RD, 8'h33, 32'h0, L_MANY, 0, 0, 32'ha, 2'b11);
        add_row(0, OP_RD, 8'h33, 32'h0, L_MANY, 0, 0, 32'hc, 2'b01);
        add_row(0, OP_RD, 8'h33, 32'h0, L_MANY, 0, 0, 32'h0, 2'b01);
        add_row(1, OP_WR, 8'h33, 32'ha, L_MANY, 0, 0, 32'h0, 2'b11);
        // threshold at the best priority
        add_row(0, OP_WR, 8'h32, 32'h6, L_MANY, 0, 0, 32'h0, 2'b01);
        add_row(1, OP_RD, 8'h33, 32'h0, L_MANY, 0, 0, 32'h0, 2'b01);
        add_row(1, OP_WR, 8'h32, 32'h5, L_MANY, 0, 0, 32'h0, 2'b11);
        // context 0 claims while the levels stay high
        add_row(0, OP_RD, 8'h31, 32'h0, L_MANY, 0, 0, 32'ha, 2'b01);
        add_row(0, OP_RD, 8'h31, 32'h0, L_MANY, 0, 1, 32'h3, 2'b01);
        add_row(0, OP_RD, 8'h20, 32'h0, L_MANY, 0, 0, 32'hf0, 2'b01);
        add_row(1, OP_WR, 8'h31, 32'h3, L_MANY, 0, 0, 32'h0, 2'b01);
        add_row(0, OP_RD, 8'h20, 32'h0, L_MANY, 0, 0, 32'hf8, 2'b01);
        add_row(0, OP_WR, 8'h31, 32'ha, L_NONE, 0, 0, 32'h0, 2'b01);
        add_row(0, OP_WR, 8'h31, 32'hc, L_NONE, 0, 0, 32'h0, 2'b01);
        // collisions on the two ports
        add_row(0, OP_BOTH, 8'h03, 32'h0, L_NONE, 0, 0, 32'h5, 2'b01);
        add_row(1, OP_RD, 8'h00, 32'h0, L_NONE, 0, 0, 32'h0, 2'b01);
        add_row(0, OP_BOTH, 8'h05, 32'h0, L_NONE, 0, 0, 32'h3, 2'b01);
        add_row(0, OP_BOTH, 8'h21, 32'h0, L_NONE, 0, 0, 32'hffff_fffe, 2'b01);
    endtask

    task automatic run_row(input row_t r, input int n);
        logic [`PLIC_NPORT-1:0]  act;
        logic [`PLIC_NPORT-1:0]  got;
        int                      lat [`PLIC_NPORT];
        int                      exp_lat [`PLIC_NPORT];
        logic [`PLIC_DATA_W-1:0] data [`PLIC_NPORT];
        logic [`PLIC_DATA_W-1:0] exp_data;
        logic [`PLIC_NCTX-1:0]   exp_ip;
        int                      cyc;
        int                      win;

        @(posedge clk);
        #1 irq = r.lvl;
        repeat (2) @(posedge clk);  // pending then the target register
        @(negedge clk);
        model_arm(r.lvl);
        check_value($sformatf("o_ip (row %0d, levels)", n), model_ip(), ip);

        act = '0;
        if (r.op == OP_BOTH) begin
            act = '1;
            win = (m_last + 1) % `PLIC_NPORT;  // port after the last grant wins
            exp_lat[win]     = 2;
            exp_lat[1 - win] = 3;
            m_last           = 1 - win;
        end else begin
            act[r.port]     = 1'b1;
            exp_lat[r.port] = 2;
            m_last          = r.port;
        end
        exp_data = model_access(r.op == OP_WR, r.addr, r.wdata);
        if (!r.mrd) begin
            exp_data = r.rdata;
        end

        @(posedge clk);
        #1;
        for (int p = 0; p < `PLIC_NPORT; p++) begin
            lat[p]  = 0;
            data[p] = '0;
            if (act[p]) begin
                req[p].wr    = r.op == OP_WR;
                req[p].addr  = r.addr;
                req[p].wdata = r.wdata;
            end
        end
        req_stb = act;
        got     = '0;
        cyc     = 0;
        while ((got & act) != act) begin
            @(posedge clk);
            #1 req_stb = '0;
            cyc++;
            @(negedge clk);
            for (int p = 0; p < `PLIC_NPORT; p++) begin
                // a strobe only ends a request that is still open
                assert (!rsp_stb[p] || (act[p] && !got[p])) else begin
                    stop_run($sformatf("row %0d: port %0d got a response it did not ask for",
                                       n, p));
                end
                if (act[p] && !got[p] && rsp_stb[p]) begin
                    got[p]  = 1'b1;
                    lat[p]  = cyc;
                    data[p] = rsp[p].rdata;
                end
            end
            assert (cyc < RSP_LIMIT || (got & act) == act) else begin
                stop_run($sformatf("row %0d: a port got no response within %0d cycles",
                                   n, RSP_LIMIT));
            end
        end

        for (int p = 0; p < `PLIC_NPORT; p++) begin
            if (act[p]) begin
                check_value($sformatf("response latency of port %0d (row %0d)", p, n),
                            exp_lat[p], lat[p]);
                if (r.op != OP_WR) begin
                    check_value($sformatf("o_rsp[%0d].rdata (row %0d)", p, n),
                                exp_data, data[p]);
                end
            end
        end

        // claim or complete reaches o_ip within three cycles
        repeat (3) @(posedge clk);
        @(negedge clk);
        model_arm(r.lvl);
        exp_ip = r.mip ? model_ip() : r.ip;
        check_value($sformatf("o_ip (row %0d)", n), exp_ip, ip);
    endtask

    initial begin
        clk     = 1'b0;
        nrst    = 1'b0;
        irq     = '0;
        req_stb = '0;
        req     = '0;
        void'($urandom(32'h922c));
        model_reset();
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 nrst = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i], i);
        end
        @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

    // each row needs at most ten cycles
    initial begin
        wait (table_ready);
        #((rows.size() * 10 + RST_CYCLES + 2) * CLK_PERIOD);
        stop_run("timeout: the table did not finish in time");
    end

endmodule

`default_nettype wire
